/* common/pmp_pkg.sv */
// PMP shared definitions
// Entry count, CSR address windows and the layout of one pmpcfg word

`default_nettype none

package pmp_pkg;

    // Number of PMP entries
    // Each pmpcfg word holds four entries, so this stays a multiple of four
    localparam int pmp_entries_c = 8;

    // Number of implemented pmpcfg words
    localparam int pmp_cfg_words_c = pmp_entries_c / 4;

    // CSR address windows for the configuration and address registers
    localparam logic [11:0] pmpcfg_base_c  = 12'h3a0;
    localparam logic [11:0] pmpaddr_base_c = 12'h3b0;
    // First address past the pmpaddr window
    localparam logic [11:0] pmpaddr_end_c  = 12'h3f0;

    // Check addresses are byte address bits 31:7, one bit per 128-byte granule
    localparam int pmp_chk_addr_w_c = 25;

    // One 32-bit pmpcfg word, seen either as a raw CSR value or as four entry bytes
    // Byte 0 belongs to the lowest-numbered entry of the word
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            // Entry is locked until reset and also binds machine mode
            logic       lock;
            logic [1:0] rsvd;
            // Only mode 3 (NAPOT) enables an entry here
            logic [1:0] match_mode;
            logic       exec;
            logic       write;
            logic       read;
        } [3:0] ent;
    } pmp_cfg_word_u;

endpackage

`default_nettype wire

/* common/pmp_entry_if.sv */
// PMP entry table bus
// Carries the decoded entry registers from the CSR file to the address checkers

`default_nettype none

interface pmp_entry_if import pmp_pkg::*; ();

    // Per-entry configuration bits, bit i belongs to entry i
    logic [pmp_entries_c-1:0] locked;
    logic [pmp_entries_c-1:0] enabled;
    logic [pmp_entries_c-1:0] exec;
    logic [pmp_entries_c-1:0] write;
    logic [pmp_entries_c-1:0] read;

    // NAPOT compare mask and base at the 128-byte granule
    // An address hits an entry when (addr & mask) == base
    logic [pmp_chk_addr_w_c-1:0] region_mask [pmp_entries_c];
    logic [pmp_chk_addr_w_c-1:0] region_base [pmp_entries_c];

    // The register file owns the table
    modport table_src (
        output locked, enabled, exec, write, read,
        output region_mask, region_base
    );

    // Checkers only look at register levels, there is no handshake
    modport table_dst (
        input locked, enabled, exec, write, read,
        input region_mask, region_base
    );

endinterface

`default_nettype wire

/* pmp/pmp_napot_decode.sv */
// NAPOT region decoder
// Turns a pmpaddr value into the compare mask and base of its naturally aligned region

`default_nettype none

module pmp_napot_decode import pmp_pkg::*; (
    // pmpaddr bits 29:4, bits 3:0 are taken as ones
    input  wire logic [pmp_chk_addr_w_c:0]   napot_addr_i,
    output logic      [pmp_chk_addr_w_c-1:0] region_mask_o,
    output logic      [pmp_chk_addr_w_c-1:0] region_base_o
);

    // High while every pmpaddr bit seen so far has been a one
    logic ones_run;

    // The region covers every bit up to and including the first zero above the
    // trailing ones
    // The four implicit low ones guarantee at least bits 4:0 of pmpaddr are
    // inside the region, which gives the 128-byte granule
    // Output bit j corresponds to pmpaddr bit j+5, i.e. napot_addr_i bit j+1
    always_comb begin
        ones_run = 1'b1;
        for (int j = 0; j < pmp_chk_addr_w_c; j++) begin
            // Bit j of the input is pmpaddr bit j+4
            // Output bit j is inside the region when all lower bits are ones
            ones_run = ones_run & napot_addr_i[j];
            region_mask_o[j] = ~ones_run;
            region_base_o[j] = napot_addr_i[j+1] & ~ones_run;
        end
    end

    // An all-ones address leaves a zero mask, which covers the whole space

endmodule

`default_nettype wire

/* pmp/pmp_csr_file.sv */
// PMP CSR register file
// Holds pmpcfg and pmpaddr state, applies machine-mode writes and the lock bit,
// and serves CSR reads together with the exists flag

`default_nettype none

module pmp_csr_file import pmp_pkg::*; (
    input  wire logic        core_clock_i,
    input  wire logic        arst_n_i,
    input  wire logic [11:0] csr_addr_i,
    input  wire logic [31:0] csr_wdata_i,
    input  wire logic        csr_we_i,
    input  wire logic        csr_mmode_i,
    output logic      [31:0] csr_rdata_o,
    output logic             csr_exists_o,
    pmp_entry_if.table_src   table_o
);

    // Per-entry configuration state
    logic [pmp_entries_c-1:0] locked_q;
    logic [pmp_entries_c-1:0] enabled_q;
    logic [pmp_entries_c-1:0] exec_q;
    logic [pmp_entries_c-1:0] write_q;
    logic [pmp_entries_c-1:0] read_q;

    // Raw pmpaddr bits 29:4 for read back, plus the decoded compare pair
    logic [pmp_chk_addr_w_c:0]   addr_q [pmp_entries_c];
    logic [pmp_chk_addr_w_c-1:0] mask_q [pmp_entries_c];
    logic [pmp_chk_addr_w_c-1:0] base_q [pmp_entries_c];

    logic                        cfg_win;
    logic                        addr_win;
    logic                        wr_ok;
    logic [pmp_entries_c-1:0]    cfg_wr_en;
    logic [pmp_entries_c-1:0]    addr_wr_en;
    pmp_cfg_word_u               wdata_u;
    pmp_cfg_word_u               cfg_rd_u;
    logic [31:0]                 addr_rd;
    logic [pmp_chk_addr_w_c-1:0] dec_mask;
    logic [pmp_chk_addr_w_c-1:0] dec_base;

    // The pmpcfg window covers all of 3a0..3af, unimplemented words read zero
    assign cfg_win  = (csr_addr_i >= pmpcfg_base_c) && (csr_addr_i < pmpaddr_base_c);
    assign addr_win = (csr_addr_i >= pmpaddr_base_c) && (csr_addr_i < pmpaddr_end_c);

    // Only machine mode may change PMP state
    assign wr_ok = csr_we_i && csr_mmode_i;

    assign wdata_u = pmp_cfg_word_u'(csr_wdata_i);

    // The write data is decoded once and captured by whichever entry is addressed
    pmp_napot_decode decode0 (
        .napot_addr_i  (csr_wdata_i[29:4]),
        .region_mask_o (dec_mask),
        .region_base_o (dec_base)
    );

    // Per-entry write enables, a locked entry ignores both of its registers
    always_comb begin
        for (int i = 0; i < pmp_entries_c; i++) begin
            cfg_wr_en[i]  = wr_ok && !locked_q[i] && cfg_win &&
                            (csr_addr_i[3:0] == 4'(i / 4));
            addr_wr_en[i] = wr_ok && !locked_q[i] &&
                            (csr_addr_i == pmpaddr_base_c + 12'(i));
        end
    end

    always_ff @(posedge core_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            locked_q  <= '0;
            enabled_q <= '0;
            exec_q    <= '0;
            write_q   <= '0;
            read_q    <= '0;
            for (int i = 0; i < pmp_entries_c; i++) begin
                addr_q[i] <= '0;
                // A cleared pmpaddr decodes to the first 128-byte granule only
                mask_q[i] <= '1;
                base_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < pmp_entries_c; i++) begin
                // Entry i sits in byte i%4 of its pmpcfg word
                if (cfg_wr_en[i]) begin
                    locked_q[i]  <= wdata_u.ent[i % 4].lock;
                    // Any mode other than NAPOT turns the entry off
                    enabled_q[i] <= &wdata_u.ent[i % 4].match_mode;
                    exec_q[i]    <= wdata_u.ent[i % 4].exec;
                    write_q[i]   <= wdata_u.ent[i % 4].write;
                    read_q[i]    <= wdata_u.ent[i % 4].read;
                end
                if (addr_wr_en[i]) begin
                    addr_q[i] <= csr_wdata_i[29:4];
                    mask_q[i] <= dec_mask;
                    base_q[i] <= dec_base;
                end
            end
        end
    end

    // Configuration read, match mode comes back as 3 or 0 and reserved bits as 0
    always_comb begin
        cfg_rd_u = '0;
        for (int w = 0; w < pmp_cfg_words_c; w++) begin
            if (csr_addr_i[3:0] == 4'(w)) begin
                for (int k = 0; k < 4; k++) begin
                    cfg_rd_u.ent[k].lock       = locked_q[w*4 + k];
                    cfg_rd_u.ent[k].match_mode = {2{enabled_q[w*4 + k]}};
                    cfg_rd_u.ent[k].exec       = exec_q[w*4 + k];
                    cfg_rd_u.ent[k].write      = write_q[w*4 + k];
                    cfg_rd_u.ent[k].read       = read_q[w*4 + k];
                end
            end
        end
    end

    // Address read, the granule bits below bit 4 always read as ones
    always_comb begin
        addr_rd = '0;
        for (int i = 0; i < pmp_entries_c; i++) begin
            if (csr_addr_i == pmpaddr_base_c + 12'(i)) begin
                addr_rd = {2'b00, addr_q[i], 4'b1111};
            end
        end
    end

    assign csr_rdata_o  = cfg_win ? cfg_rd_u.raw : addr_rd;
    assign csr_exists_o = (cfg_win || addr_win) && csr_mmode_i;

    // Publish the table to the checkers
    assign table_o.locked      = locked_q;
    assign table_o.enabled     = enabled_q;
    assign table_o.exec        = exec_q;
    assign table_o.write       = write_q;
    assign table_o.read        = read_q;
    assign table_o.region_mask = mask_q;
    assign table_o.region_base = base_q;

endmodule

`default_nettype wire

/* pmp/pmp_match_prio.sv */
// PMP priority matcher
// Finds the lowest-numbered enabled entry that contains an address
// and returns that entry's lock and permission bits

`default_nettype none

module pmp_match_prio import pmp_pkg::*; (
    input  wire logic [pmp_chk_addr_w_c-1:0] chk_addr_i,
    pmp_entry_if.table_dst                   table_i,
    output logic                             hit_o,
    output logic                             hit_locked_o,
    output logic                             hit_exec_o,
    output logic                             hit_write_o,
    output logic                             hit_read_o
);

    // Scan from entry 0 upward, the first hit blocks every later entry
    always_comb begin
        hit_o        = 1'b0;
        hit_locked_o = 1'b0;
        hit_exec_o   = 1'b0;
        hit_write_o  = 1'b0;
        hit_read_o   = 1'b0;
        for (int i = 0; i < pmp_entries_c; i++) begin
            if (!hit_o && table_i.enabled[i] &&
                ((chk_addr_i & table_i.region_mask[i]) == table_i.region_base[i])) begin
                hit_o        = 1'b1;
                hit_locked_o = table_i.locked[i];
                hit_exec_o   = table_i.exec[i];
                hit_write_o  = table_i.write[i];
                hit_read_o   = table_i.read[i];
            end
        end
    end

    // On a miss all permission outputs stay zero

endmodule

`default_nettype wire

/* pmp/pmp_access_check.sv */
// PMP access checker
// Looks up the fetch and data addresses in the entry table and applies
// the privilege and permission rules to give the two kill signals

`default_nettype none

module pmp_access_check import pmp_pkg::*; (
    pmp_entry_if.table_dst                   table_i,
    input  wire logic [pmp_chk_addr_w_c-1:0] fetch_addr_i,
    input  wire logic                        fetch_mmode_i,
    input  wire logic [pmp_chk_addr_w_c-1:0] data_addr_i,
    input  wire logic                        data_mmode_i,
    input  wire logic                        data_write_i,
    output logic                             fetch_kill_o,
    output logic                             data_kill_o
);

    logic fetch_hit;
    logic fetch_locked;
    logic fetch_exec;
    logic data_hit;
    logic data_locked;
    logic data_write;
    logic data_read;
    logic data_allow;

    // Fetch lookup, only execute permission matters
    pmp_match_prio fetch_match0 (
        .chk_addr_i   (fetch_addr_i),
        .table_i      (table_i),
        .hit_o        (fetch_hit),
        .hit_locked_o (fetch_locked),
        .hit_exec_o   (fetch_exec),
        .hit_write_o  (),
        .hit_read_o   ()
    );

    // Data lookup, execute permission does not apply
    pmp_match_prio data_match0 (
        .chk_addr_i   (data_addr_i),
        .table_i      (table_i),
        .hit_o        (data_hit),
        .hit_locked_o (data_locked),
        .hit_exec_o   (),
        .hit_write_o  (data_write),
        .hit_read_o   (data_read)
    );

    // Stores need write permission and loads need read permission
    assign data_allow = data_write_i ? data_write : data_read;

    // Machine mode is only bound by locked entries
    // User mode needs a hit that grants the access
    assign fetch_kill_o = fetch_mmode_i ? (fetch_hit && fetch_locked && !fetch_exec)
                                        : !(fetch_hit && fetch_exec);

    assign data_kill_o = data_mmode_i ? (data_hit && data_locked && !data_allow)
                                      : !(data_hit && data_allow);

endmodule

`default_nettype wire

/* rtl/pmp_unit.sv */
// PMP unit top level
// Machine-mode pmpcfg/pmpaddr registers with combinational fetch and data checks

`default_nettype none

module pmp_unit import pmp_pkg::*; (
    input  wire logic                        core_clock_i,
    input  wire logic                        arst_n_i,

    // CSR access, writes land on the next rising edge
    input  wire logic [11:0]                 csr_addr_i,
    input  wire logic [31:0]                 csr_wdata_i,
    input  wire logic                        csr_we_i,
    output logic      [31:0]                 csr_rdata_o,
    output logic                             csr_exists_o,

    // Instruction fetch check
    input  wire logic [pmp_chk_addr_w_c-1:0] fetch_addr_i,
    input  wire logic                        fetch_mmode_i,
    output logic                             fetch_kill_o,

    // Data access check
    input  wire logic [pmp_chk_addr_w_c-1:0] data_addr_i,
    input  wire logic                        data_mmode_i,
    input  wire logic                        data_write_i,
    output logic                             data_kill_o
);

    // Decoded entry table shared by the register file and the checker
    pmp_entry_if entry_bus ();

    // The fetch privilege level also qualifies CSR accesses
    pmp_csr_file csr_file0 (
        .core_clock_i (core_clock_i),
        .arst_n_i     (arst_n_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_we_i     (csr_we_i),
        .csr_mmode_i  (fetch_mmode_i),
        .csr_rdata_o  (csr_rdata_o),
        .csr_exists_o (csr_exists_o),
        .table_o      (entry_bus.table_src)
    );

    pmp_access_check check0 (
        .table_i       (entry_bus.table_dst),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_mmode_i (fetch_mmode_i),
        .data_addr_i   (data_addr_i),
        .data_mmode_i  (data_mmode_i),
        .data_write_i  (data_write_i),
        .fetch_kill_o  (fetch_kill_o),
        .data_kill_o   (data_kill_o)
    );

endmodule

`default_nettype wire

/* verif/pmp_unit_assertions.sv */
// PMP unit assertions
// Watches the kill outputs and the CSR exists flag of the top level

`default_nettype none

module pmp_unit_assertions import pmp_pkg::*; (
    input wire logic                     core_clock_i,
    input wire logic                     arst_n_i,
    input wire logic                     mmode_i,
    input wire logic                     exists_i,
    input wire logic                     fetch_kill_i,
    input wire logic                     data_kill_i,
    input wire logic [pmp_entries_c-1:0] locked_i
);

    // Both kill outputs are defined once reset is released
    kill_known_a: assert property (
        @(posedge core_clock_i) disable iff (!arst_n_i)
        !$isunknown({fetch_kill_i, data_kill_i})
    ) else $error("kill output unknown after reset");

    // The PMP CSRs only exist for machine mode
    exists_mmode_a: assert property (
        @(posedge core_clock_i) disable iff (!arst_n_i)
        exists_i |-> mmode_i
    ) else $error("csr exists flag high outside machine mode");

    // Without a locked entry machine mode is never restricted
    mmode_unlocked_a: assert property (
        @(posedge core_clock_i) disable iff (!arst_n_i)
        (mmode_i && locked_i == '0) |-> !fetch_kill_i
    ) else $error("machine-mode fetch killed with no locked entry");

endmodule

bind pmp_unit pmp_unit_assertions assertions0 (
    .core_clock_i (core_clock_i),
    .arst_n_i     (arst_n_i),
    .mmode_i      (fetch_mmode_i),
    .exists_i     (csr_exists_o),
    .fetch_kill_i (fetch_kill_o),
    .data_kill_i  (data_kill_o),
    .locked_i     (entry_bus.locked)
);

`default_nettype wire

/* verif/pmp_unit_tb.sv */
// PMP unit testbench
// Seeded random CSR traffic and fetch/data checks compared against a behavioral model

`default_nettype none

module pmp_unit_tb import pmp_pkg::*; ();

    localparam int reset_cycles_c = 10;
    localparam int n_csr_ops_c    = 96;
    localparam int n_exists_c     = 48;
    localparam int n_fetch_c      = 500;
    localparam int n_data_c       = 500;
    // Stimulus cycles of all tests, the directed steps fit in the fixed slack
    localparam int total_cycles_c = 2 * reset_cycles_c + 2 * n_csr_ops_c + n_exists_c
                                    + n_fetch_c + n_data_c + 80;

    logic        core_clock;
    logic        arst_n;
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
    logic        csr_we;
    logic [31:0] csr_rdata;
    logic        csr_exists;
    logic [24:0] fetch_addr;
    logic        fetch_mmode;
    logic        fetch_kill;
    logic [24:0] data_addr;
    logic        data_mmode;
    logic        data_write;
    logic        data_kill;

    // Reference entry table, updated by the same write rules as the registers
    logic [pmp_entries_c-1:0] m_lock;
    logic [pmp_entries_c-1:0] m_en;
    logic [pmp_entries_c-1:0] m_x;
    logic [pmp_entries_c-1:0] m_w;
    logic [pmp_entries_c-1:0] m_r;
    logic [pmp_chk_addr_w_c:0] m_addr [pmp_entries_c];

    int pass_count;
    int fail_count;
    int test_fails;

    pmp_unit dut0 (
        .core_clock_i  (core_clock),
        .arst_n_i      (arst_n),
        .csr_addr_i    (csr_addr),
        .csr_wdata_i   (csr_wdata),
        .csr_we_i      (csr_we),
        .csr_rdata_o   (csr_rdata),
        .csr_exists_o  (csr_exists),
        .fetch_addr_i  (fetch_addr),
        .fetch_mmode_i (fetch_mmode),
        .fetch_kill_o  (fetch_kill),
        .data_addr_i   (data_addr),
        .data_mmode_i  (data_mmode),
        .data_write_i  (data_write),
        .data_kill_o   (data_kill)
    );

    always #5 core_clock = ~core_clock;

    // Inputs change 1 unit after the edge, and outputs are sampled at edge minus 1
    task automatic next_cycle();
        @(posedge core_clock);
        #1;
        csr_we = 1'b0;
    endtask

    task automatic settle();
        #8;
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (reset_cycles_c) @(posedge core_clock);
        #1;
        arst_n = 1'b1;
        m_lock = '0;
        m_en   = '0;
        m_x    = '0;
        m_w    = '0;
        m_r    = '0;
        for (int i = 0; i < pmp_entries_c; i++) begin
            m_addr[i] = '0;
        end
    endtask

    task automatic compare_bit(string what, logic got, logic expected);
        if (got !== expected) begin
            fail_count++;
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, what, got, expected);
        end else begin
            pass_count++;
        end
    endtask

    task automatic compare_word(string what, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            fail_count++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, expected);
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_test(string name);
        $display("Test %s: %s, %0d errors", name,
                 (fail_count == test_fails) ? "ok" : "failed", fail_count - test_fails);
        test_fails = fail_count;
    endtask

    function automatic logic in_window(logic [11:0] addr);
        return (addr >= pmpcfg_base_c) && (addr < pmpaddr_end_c);
    endfunction

    // pmpaddr holds byte address bits 33:2, and t trailing ones give 2^(t+3) bytes
    function automatic void region_of(input int idx, output logic [63:0] base_byte,
                                      output int size_log2);
        logic [63:0] pa;
        int ones;
        pa = {34'd0, m_addr[idx], 4'b1111};
        ones = 0;
        while (ones < 30 && pa[ones]) begin
            ones++;
        end
        size_log2 = ones + 3;
        // The first zero and everything below it leave the base
        base_byte = (pa >> (ones + 1)) << size_log2;
    endfunction

    function automatic logic in_region(int idx, logic [24:0] chk);
        logic [63:0] base_byte;
        logic [63:0] byte_addr;
        int size_log2;
        region_of(idx, base_byte, size_log2);
        byte_addr = {32'd0, chk, 7'd0};
        return (byte_addr >> size_log2) == (base_byte >> size_log2);
    endfunction

    // Random check address somewhere inside the region of one entry
    function automatic logic [24:0] addr_in_entry(int idx);
        logic [63:0] base_byte;
        logic [63:0] byte_addr;
        int size_log2;
        region_of(idx, base_byte, size_log2);
        byte_addr = base_byte + ({32'd0, $urandom} & ((64'd1 << size_log2) - 64'd1));
        return byte_addr[31:7];
    endfunction

    // Mostly the low 256 KiB where the random regions live, sometimes anywhere
    function automatic logic [24:0] random_chk_addr();
        logic [24:0] chk;
        chk = 25'($urandom_range(2047));
        if ($urandom_range(7) == 0) begin
            chk = 25'($urandom);
        end
        return chk;
    endfunction

    // NAPOT pmpaddr value with 4 to max_ones trailing ones; bits 31:30 are junk
    function automatic logic [31:0] random_napot(int max_ones);
        int t;
        logic [31:0] low_ones;
        logic [31:0] value;
        t = 4 + int'($urandom_range(max_ones - 4));
        low_ones = (32'd1 << t) - 32'd1;
        value = $urandom & 32'hc000_ffff;
        return (value & ~((low_ones << 1) | 32'd1)) | low_ones;
    endfunction

    function automatic logic [31:0] random_cfg_word();
        pmp_cfg_word_u cw;
        for (int k = 0; k < 4; k++) begin
            cw.ent[k].lock       = ($urandom_range(3) == 0);
            cw.ent[k].rsvd       = 2'($urandom);
            cw.ent[k].match_mode = ($urandom_range(3) != 0) ? 2'b11 : 2'($urandom);
            cw.ent[k].exec       = 1'($urandom);
            cw.ent[k].write      = 1'($urandom);
            cw.ent[k].read       = 1'($urandom);
        end
        return cw.raw;
    endfunction

    function automatic void model_write(logic [11:0] addr, logic [31:0] wdata, logic mmode);
        pmp_cfg_word_u cw;
        int idx;
        cw.raw = wdata;
        if (mmode && addr >= pmpcfg_base_c && addr < pmpcfg_base_c + 12'(pmp_cfg_words_c)) begin
            for (int k = 0; k < 4; k++) begin
                idx = 4 * int'(addr - pmpcfg_base_c) + k;
                // A locked entry keeps its whole configuration
                if (!m_lock[idx]) begin
                    m_lock[idx] = cw.ent[k].lock;
                    m_en[idx]   = (cw.ent[k].match_mode == 2'b11);
                    m_x[idx]    = cw.ent[k].exec;
                    m_w[idx]    = cw.ent[k].write;
                    m_r[idx]    = cw.ent[k].read;
                end
            end
        end
        if (mmode && addr >= pmpaddr_base_c && addr < pmpaddr_base_c + 12'(pmp_entries_c)) begin
            idx = int'(addr - pmpaddr_base_c);
            if (!m_lock[idx]) begin
                m_addr[idx] = wdata[29:4];
            end
        end
    endfunction

    // Unimplemented words in either window read as zero
    function automatic logic [31:0] model_read(logic [11:0] addr);
        pmp_cfg_word_u cw;
        int idx;
        cw.raw = '0;
        if (addr >= pmpcfg_base_c && addr < pmpcfg_base_c + 12'(pmp_cfg_words_c)) begin
            for (int k = 0; k < 4; k++) begin
                idx = 4 * int'(addr - pmpcfg_base_c) + k;
                cw.ent[k].lock       = m_lock[idx];
                cw.ent[k].match_mode = m_en[idx] ? 2'b11 : 2'b00;
                cw.ent[k].exec       = m_x[idx];
                cw.ent[k].write      = m_w[idx];
                cw.ent[k].read       = m_r[idx];
            end
        end
        if (addr >= pmpaddr_base_c && addr < pmpaddr_base_c + 12'(pmp_entries_c)) begin
            cw.raw = {2'b00, m_addr[int'(addr - pmpaddr_base_c)], 4'b1111};
        end
        return cw.raw;
    endfunction

    // Scanning downward leaves the lowest-numbered matching entry in hit
    function automatic logic expect_kill(logic [24:0] chk, logic mmode, logic is_fetch,
                                         logic is_store);
        int hit;
        logic perm;
        logic kill;
        hit = -1;
        for (int i = pmp_entries_c - 1; i >= 0; i--) begin
            if (m_en[i] && in_region(i, chk)) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            kill = !mmode;
        end else begin
            perm = is_fetch ? m_x[hit] : (is_store ? m_w[hit] : m_r[hit]);
            kill = mmode ? (m_lock[hit] && !perm) : !perm;
        end
        return kill;
    endfunction

    task automatic csr_write(logic [11:0] addr, logic [31:0] wdata, logic mmode);
        next_cycle();
        csr_addr    = addr;
        csr_wdata   = wdata;
        csr_we      = 1'b1;
        fetch_mmode = mmode;
        settle();
        compare_bit($sformatf("exists on write %h", addr), csr_exists, in_window(addr) && mmode);
        model_write(addr, wdata, mmode);
    endtask

    task automatic read_expect(logic [11:0] addr, logic [31:0] expected);
        next_cycle();
        csr_addr    = addr;
        fetch_mmode = 1'b1;
        settle();
        compare_word($sformatf("read %h", addr), csr_rdata, expected);
    endtask

    task automatic fetch_check(logic [24:0] addr, logic mmode, logic expected);
        next_cycle();
        fetch_addr  = addr;
        fetch_mmode = mmode;
        settle();
        compare_bit($sformatf("fetch kill %h m=%b", addr, mmode), fetch_kill, expected);
    endtask

    task automatic data_check(logic [24:0] addr, logic mmode, logic store, logic expected);
        next_cycle();
        data_addr  = addr;
        data_mmode = mmode;
        data_write = store;
        settle();
        compare_bit($sformatf("data kill %h m=%b st=%b", addr, mmode, store), data_kill,
                    expected);
    endtask

    initial begin
        logic [11:0]   addr;
        logic [31:0]   wdata;
        logic [24:0]   chk;
        logic          mmode;
        logic          store;
        int            idx;
        pmp_cfg_word_u cw;
        void'($urandom(32'h585c_3f55));
        pass_count  = 0;
        fail_count  = 0;
        test_fails  = 0;
        core_clock  = 1'b0;
        arst_n      = 1'b0;
        csr_addr    = '0;
        csr_wdata   = '0;
        csr_we      = 1'b0;
        fetch_addr  = '0;
        fetch_mmode = 1'b0;
        data_addr   = '0;
        data_mmode  = 1'b0;
        data_write  = 1'b0;
        apply_reset();

        // Cleared table: user mode misses everywhere, machine mode passes
        for (int w = 0; w < pmp_cfg_words_c; w++) begin
            read_expect(pmpcfg_base_c + 12'(w), 32'h0000_0000);
        end
        for (int i = 0; i < pmp_entries_c; i++) begin
            read_expect(pmpaddr_base_c + 12'(i), 32'h0000_000f);
        end
        for (int n = 0; n < 4; n++) begin
            next_cycle();
            fetch_addr  = 25'($urandom);
            fetch_mmode = n[0];
            data_addr   = 25'($urandom);
            data_mmode  = n[0];
            data_write  = 1'($urandom);
            settle();
            compare_bit("fetch kill after reset", fetch_kill, !n[0]);
            compare_bit("data kill after reset", data_kill, !n[0]);
        end
        // An entry enabled straight after reset covers only the first granule
        csr_write(pmpcfg_base_c, 32'h0000_001f, 1'b1);
        fetch_check(25'd0, 1'b0, expect_kill(25'd0, 1'b0, 1'b1, 1'b0));
        fetch_check(25'd1, 1'b0, expect_kill(25'd1, 1'b0, 1'b1, 1'b0));
        report_test("1 reset state");

        for (int n = 0; n < n_csr_ops_c; n++) begin
            idx = int'($urandom_range(9));
            if (idx < 2) begin
                addr = pmpcfg_base_c + 12'(idx);
            end else if (idx < 8) begin
                addr = pmpaddr_base_c + 12'($urandom_range(pmp_entries_c - 1));
            end else begin
                addr = pmpcfg_base_c + 12'($urandom_range(79));
            end
            mmode = ($urandom_range(3) != 0);
            wdata = $urandom;
            // Locking gets its own test
            if (addr < pmpaddr_base_c) begin
                wdata = wdata & 32'h7f7f_7f7f;
            end
            csr_write(addr, wdata, mmode);
            read_expect(addr, model_read(addr));
        end
        for (int n = 0; n < n_exists_c; n++) begin
            next_cycle();
            csr_addr    = 12'h380 + 12'($urandom_range(127));
            fetch_mmode = 1'($urandom);
            settle();
            compare_bit($sformatf("exists %h", csr_addr), csr_exists,
                        in_window(csr_addr) && fetch_mmode);
        end
        report_test("2 register access");

        // Entry 2 becomes a locked read-only region, then an unlock is attempted
        csr_write(pmpaddr_base_c + 12'd2, random_napot(12), 1'b1);
        cw.raw = '0;
        cw.ent[2].lock       = 1'b1;
        cw.ent[2].match_mode = 2'b11;
        cw.ent[2].read       = 1'b1;
        csr_write(pmpcfg_base_c, cw.raw, 1'b1);
        read_expect(pmpcfg_base_c, 32'h0099_0000);
        csr_write(pmpaddr_base_c + 12'd2, random_napot(12), 1'b1);
        cw.raw = '0;
        cw.ent[2].match_mode = 2'b11;
        cw.ent[2].exec       = 1'b1;
        cw.ent[2].write      = 1'b1;
        cw.ent[2].read       = 1'b1;
        csr_write(pmpcfg_base_c, cw.raw, 1'b1);
        read_expect(pmpcfg_base_c, 32'h0099_0000);
        read_expect(pmpaddr_base_c + 12'd2, model_read(pmpaddr_base_c + 12'd2));
        for (int n = 0; n < 4; n++) begin
            chk = addr_in_entry(2);
            fetch_check(chk, 1'b1, 1'b1);
            data_check(chk, 1'b1, 1'b1, 1'b1);
            data_check(chk, 1'b1, 1'b0, 1'b0);
        end
        report_test("3 lock");

        // Overlapping random regions in all entries, some of them locked
        apply_reset();
        for (int i = 0; i < pmp_entries_c; i++) begin
            csr_write(pmpaddr_base_c + 12'(i), random_napot(14), 1'b1);
        end
        for (int w = 0; w < pmp_cfg_words_c; w++) begin
            csr_write(pmpcfg_base_c + 12'(w), random_cfg_word(), 1'b1);
            read_expect(pmpcfg_base_c + 12'(w), model_read(pmpcfg_base_c + 12'(w)));
        end
        for (int n = 0; n < n_fetch_c; n++) begin
            idx   = int'($urandom_range(2 * pmp_entries_c - 1));
            chk   = (idx < pmp_entries_c) ? addr_in_entry(idx) : random_chk_addr();
            mmode = 1'($urandom);
            fetch_check(chk, mmode, expect_kill(chk, mmode, 1'b1, 1'b0));
        end
        report_test("4 fetch priority");

        for (int n = 0; n < n_data_c; n++) begin
            idx   = int'($urandom_range(2 * pmp_entries_c - 1));
            chk   = (idx < pmp_entries_c) ? addr_in_entry(idx) : random_chk_addr();
            mmode = 1'($urandom);
            store = 1'($urandom);
            data_check(chk, mmode, store, expect_kill(chk, mmode, 1'b0, store));
        end
        report_test("5 data access");

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Twice the planned stimulus time plus a margin
    initial begin
        #(total_cycles_c * 20 + 500);
        $display("Watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* pmp_unit.f */
common/pmp_pkg.sv
common/pmp_entry_if.sv
pmp/pmp_napot_decode.sv
pmp/pmp_csr_file.sv
pmp/pmp_match_prio.sv
pmp/pmp_access_check.sv
rtl/pmp_unit.sv
verif/pmp_unit_assertions.sv
verif/pmp_unit_tb.sv

/* Makefile */
# Verilator build and run of the PMP unit testbench

TOP := pmp_unit_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f pmp_unit.f
	@out="$$(./obj_dir/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only -Wall --timing --top-module pmp_unit -f pmp_unit.f

clean:
	rm -rf obj_dir
